// File: rtl/fifo_cfg_pkg.sv
//##########################################################
// fifo depths, lfsr polynomial and seed, chaos bit picks
//##########################################################

package fifo_cfg_pkg;

   //##########################################################
   // fifo sizing
   //##########################################################

   // ingress fifo depth, not a power of two on purpose
   localparam int IN_DEPTH  = 5;
   localparam int OUT_DEPTH = 3;   // egress fifo depth

   //##########################################################
   // chaos source
   //##########################################################

   localparam int LFSR_W = 16;     // lfsr state width

   // any nonzero value works, all-zero locks up
   localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;

   // galois mask for x^16 + x^14 + x^13 + x^11 + 1
   localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

   // state bits that drive chaos full, kept apart
   // so the two fifos don't stall in lockstep
   localparam int CHAOS_IN_BIT  = 3;    // ingress fifo
   localparam int CHAOS_OUT_BIT = 11;   // egress fifo

endpackage : fifo_cfg_pkg

// File: rtl/link_types_pkg.sv
//##########################################################
// ingress and egress word structs, payload and seq widths
//##########################################################

package link_types_pkg;

   //##########################################################
   // widths
   //##########################################################

   localparam int DATA_W = 32;   // payload bits per word
   localparam int SEQ_W  = 8;    // sequence number, wraps at 256

   //##########################################################
   // ingress word, as written by the host
   //##########################################################

   // 33 bits in all
   typedef struct packed {
      logic [DATA_W-1:0] data;   // payload
      logic              last;   // end of packet marker
   } in_word_t;

   //##########################################################
   // egress word, after tagging
   //##########################################################

   // 42 bits in all
   // parity is xor of data, so data plus parity has even weight
   typedef struct packed {
      logic [DATA_W-1:0] data;     // payload, unchanged
      logic [SEQ_W-1:0]  seq;      // transfer index mod 256
      logic              parity;   // even parity over data
      logic              last;     // copied from ingress word
   } out_word_t;

endpackage : link_types_pkg

// File: rtl/la_lfsr.sv
`timescale 1ns/100ps
//##########################################################
// free-running galois lfsr, pseudo-random chaos bits
//##########################################################

module la_lfsr
(
   input  logic                            clk,
   input  logic                            nreset,
   output logic [fifo_cfg_pkg::LFSR_W-1:0] state   // full lfsr state
);

   import fifo_cfg_pkg::*;

   logic              feedback;    // bit shifted out this cycle
   logic [LFSR_W-1:0] state_nxt;

   //##########################################################
   // next state
   //##########################################################

   // galois form
   // shift right, fold the tap mask back in when a one drops out
   assign feedback  = state[0];
   assign state_nxt = (state >> 1) ^ (feedback ? LFSR_TAPS : '0);

   //##########################################################
   // state register
   //##########################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state <= LFSR_SEED;   // nonzero, else stuck forever
      end
      else
      begin
         state <= state_nxt;   // advances every cycle, no enable
      end
   end

endmodule : la_lfsr

// File: rtl/la_syncfifo.sv
`timescale 1ns/100ps
//##########################################################
// synchronous fifo of any depth, type-parameter payload
// fall-through read port, optional random full in chaos mode
//##########################################################

module la_syncfifo
#(
   parameter type T     = logic [31:0],   // payload type
   parameter int  DEPTH = 4               // words, any value >= 1
)
(
   // clock and reset
   input  logic clk,
   input  logic nreset,
   // random full control
   input  logic chaos,       // pseudo-random bit from the lfsr
   input  logic chaosmode,   // gates chaos onto wr_full
   // write side
   input  logic wr_en,       // push request
   input  T     wr_din,      // word to push
   output logic wr_full,     // no push accepted this cycle
   // read side
   input  logic rd_en,       // pop request
   output T     rd_dout,     // head word, valid while not empty
   output logic rd_empty     // nothing to pop
);

   // address bits, at least one so a single-word fifo still builds
   localparam int            AW        = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);   // wrap point

   // pointers are {lap, addr}
   // lap flips each time addr wraps past LAST_ADDR
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic        ptr_full;     // occupancy full
   logic        fifo_write;   // qualified push
   logic        fifo_read;    // qualified pop

   T mem [DEPTH];             // storage, no reset

   //##########################################################
   // pointer increment
   //##########################################################

   // wraps at DEPTH-1 instead of the power of two
   function automatic logic [AW:0] ptr_inc(input logic [AW:0] ptr);
      logic [AW:0] nxt;
      if (ptr[AW-1:0] == LAST_ADDR)
      begin
         nxt = {~ptr[AW], {AW{1'b0}}};   // new lap, address 0
      end
      else
      begin
         nxt = {ptr[AW], ptr[AW-1:0] + 1'b1};
      end
      return nxt;
   endfunction

   //##########################################################
   // full and empty
   //##########################################################

   // same address on different laps means every slot is taken
   assign ptr_full = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign wr_full  = ptr_full | (chaos & chaosmode);   // chaos fakes full
   assign rd_empty = (wr_ptr == rd_ptr);               // same lap and addr

   assign fifo_write = wr_en & ~wr_full;    // writes dropped when full
   assign fifo_read  = rd_en & ~rd_empty;   // reads ignored when empty

   //##########################################################
   // pointer registers
   //##########################################################

   // push and pop in one cycle move both pointers
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (fifo_write)
            wr_ptr <= ptr_inc(wr_ptr);
         if (fifo_read)
            rd_ptr <= ptr_inc(rd_ptr);
      end
   end

   //##########################################################
   // memory
   //##########################################################

   always_ff @(posedge clk)
   begin
      if (fifo_write)
         mem[wr_ptr[AW-1:0]] <= wr_din;
   end

   // fall-through, head word straight from the array
   assign rd_dout = mem[rd_ptr[AW-1:0]];

endmodule : la_syncfifo

// File: rtl/link_tagger.sv
`timescale 1ns/100ps
//##########################################################
// ingress to egress mover, adds sequence number and parity
//##########################################################

module link_tagger
(
   // clock and reset
   input  logic                      clk,
   input  logic                      nreset,
   // ingress fifo read side
   input  link_types_pkg::in_word_t  in_head,    // fall-through head word
   input  logic                      in_empty,   // nothing to move
   output logic                      in_pop,     // pops the head word
   // egress fifo write side
   input  logic                      out_full,   // real or chaos full
   output logic                      out_push,   // pushes out_word
   output link_types_pkg::out_word_t out_word    // tagged word
);

   import link_types_pkg::*;

   logic             xfer;   // one word moves this cycle
   logic [SEQ_W-1:0] seq;    // tag for the next word moved

   //##########################################################
   // transfer control
   //##########################################################

   // purely combinational, no staging register
   // word leaves ingress and lands in egress on the same edge
   assign xfer     = ~in_empty & ~out_full;
   assign in_pop   = xfer;
   assign out_push = xfer;

   //##########################################################
   // tagged word
   //##########################################################

   // built from the head word every cycle
   // only meaningful while out_push is high
   always_comb
   begin
      out_word.data   = in_head.data;     // payload untouched
      out_word.seq    = seq;              // current count
      out_word.parity = ^in_head.data;    // even parity
      out_word.last   = in_head.last;
   end

   //##########################################################
   // sequence counter
   //##########################################################

   // counts transfers, not host writes
   // same thing since neither fifo drops an accepted word
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         seq <= '0;
      end
      else if (xfer)
      begin
         seq <= seq + 1'b1;   // 255 rolls over to 0
      end
   end

endmodule : link_tagger

// File: rtl/la_fifo_link.sv
`timescale 1ns/100ps
//##########################################################
// word link top, ingress fifo, tagger, egress fifo, lfsr
//##########################################################

module la_fifo_link
(
   // clock and reset
   input  logic                      clk,
   input  logic                      nreset,
   input  logic                      chaosmode,   // random full enable
   // host side
   input  logic                      in_wr,       // write strobe
   input  link_types_pkg::in_word_t  in_word,     // word to send
   output logic                      in_full,     // write gets dropped
   // consumer side
   input  logic                      out_rd,      // pop strobe
   output link_types_pkg::out_word_t out_word,    // valid while not empty
   output logic                      out_empty
);

   import fifo_cfg_pkg::*;
   import link_types_pkg::*;

   logic [LFSR_W-1:0] lfsr_state;   // shared chaos source
   in_word_t          in_head;      // ingress head, fall-through
   logic              in_empty;
   logic              in_pop;       // tagger pops ingress
   logic              eg_full;      // egress back-pressure to tagger
   logic              eg_push;      // tagger pushes egress
   out_word_t         eg_word;      // tagged word into egress

   //##########################################################
   // chaos source
   //##########################################################

   la_lfsr u_lfsr (
      .clk    (clk),
      .nreset (nreset),
      .state  (lfsr_state)
   );

   //##########################################################
   // ingress fifo, host writes, tagger reads
   //##########################################################

   la_syncfifo #(
      .T     (in_word_t),
      .DEPTH (IN_DEPTH)
   ) u_in_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .chaos     (lfsr_state[CHAOS_IN_BIT]),   // host-side stalls
      .chaosmode (chaosmode),
      .wr_en     (in_wr),
      .wr_din    (in_word),
      .wr_full   (in_full),
      .rd_en     (in_pop),
      .rd_dout   (in_head),
      .rd_empty  (in_empty)
   );

   //##########################################################
   // tagger, seq and parity
   //##########################################################

   link_tagger u_tagger (
      .clk      (clk),
      .nreset   (nreset),
      .in_head  (in_head),
      .in_empty (in_empty),
      .in_pop   (in_pop),
      .out_full (eg_full),
      .out_push (eg_push),
      .out_word (eg_word)
   );

   //##########################################################
   // egress fifo, tagger writes, consumer reads
   //##########################################################

   la_syncfifo #(
      .T     (out_word_t),
      .DEPTH (OUT_DEPTH)
   ) u_out_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .chaos     (lfsr_state[CHAOS_OUT_BIT]),  // internal stalls
      .chaosmode (chaosmode),
      .wr_en     (eg_push),
      .wr_din    (eg_word),
      .wr_full   (eg_full),
      .rd_en     (out_rd),
      .rd_dout   (out_word),
      .rd_empty  (out_empty)
   );

endmodule : la_fifo_link

// File: verification/tb_clkgen.sv
`timescale 1ns/100ps
//##########################################################
// testbench clock, 8 ns period, and reset generator
//##########################################################

module tb_clkgen
(
   output logic clk,
   output logic nreset
);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 125 MHz
   end

   // low for two rising edges, released mid-cycle
   initial
   begin
      nreset = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
   end

endmodule : tb_clkgen

// File: verification/tb_la_fifo_link.sv
`timescale 1ns/100ps
//##########################################################
// table-driven testbench for the fifo link
// reference queue, scoreboard, watchdog
//##########################################################

module tb_la_fifo_link;

   import fifo_cfg_pkg::*;
   import link_types_pkg::*;

   localparam int CAP     = IN_DEPTH + OUT_DEPTH;   // words the link can hold
   localparam int N_TESTS = 4;

   // one row per table-driven test
   typedef struct packed {
      logic [95:0] name;         // ascii name up to 12 chars
      int unsigned words;        // words to get accepted
      logic        chaos;        // chaosmode level
      int unsigned wr_pct;       // write attempt rate
      int unsigned rd_pct;       // read rate after holdoff
      int unsigned holdoff;      // cycles with out_rd low
      int unsigned expect_cap;   // accepted by end of holdoff or 0 to skip
      logic        idle_rd;      // reads on empty must occur
   } test_t;

   localparam test_t TESTS [N_TESTS] = '{
      '{"ordered",      40,  1'b0, 100, 100, 0,  0,   1'b0},
      '{"backpressure", 12,  1'b0, 100, 100, 20, CAP, 1'b0},
      '{"chaos",        300, 1'b1, 70,  60,  0,  0,   1'b0},
      '{"read_empty",   6,   1'b0, 15,  100, 0,  0,   1'b1}
   };

   logic      clk;
   logic      nreset;
   logic      chaosmode;
   logic      in_wr;
   in_word_t  in_word;
   logic      in_full;
   logic      out_rd;
   out_word_t out_word;
   logic      out_empty;

   out_word_t   model [$];          // accepted but not yet popped
   int unsigned accept_total = 0;   // acceptance index that gives seq
   int unsigned accepted;           // per test
   int unsigned test_errors;
   int unsigned errors       = 0;
   int unsigned tests_run    = 0;
   int unsigned tests_failed = 0;
   int unsigned empty_reads;        // out_rd high on empty
   logic        chaos_seen;         // in_full below capacity
   logic        wrap_seen    = 1'b0;
   int unsigned wrap_errors  = 0;
   logic [7:0]  prev_seq;
   logic        prev_valid   = 1'b0;

   tb_clkgen u_clkgen (
      .clk    (clk),
      .nreset (nreset)
   );

   la_fifo_link u_la_fifo_link (
      .clk       (clk),
      .nreset    (nreset),
      .chaosmode (chaosmode),
      .in_wr     (in_wr),
      .in_word   (in_word),
      .in_full   (in_full),
      .out_rd    (out_rd),
      .out_word  (out_word),
      .out_empty (out_empty)
   );

   //##########################################################
   // helpers
   //##########################################################

   function automatic string name_of(input logic [95:0] raw);
      string s;
      s = "";
      for (int i = 11; i >= 0; i--)
         if (raw[i*8 +: 8] != 8'h00)
            s = $sformatf("%s%c", s, raw[i*8 +: 8]);   // skip zero padding
      return s;
   endfunction

   // xor of every data bit
   function automatic logic data_parity(input logic [DATA_W-1:0] d);
      logic p;
      p = 1'b0;
      for (int i = 0; i < DATA_W; i++)
         p = p ^ d[i];
      return p;
   endfunction

   // called at the falling edge to predict the coming rising edge
   task automatic sample_cycle(input string name);
      out_word_t exp;
      if (chaosmode && in_full && model.size() < CAP)
         chaos_seen = 1'b1;
      if (out_rd && out_empty)
         empty_reads++;
      assert (model.size() != 0 || out_empty)
      else
      begin
         $display("FAILED %s: expected out_empty %b actual %b", name, 1'b1, out_empty);
         test_errors++;
      end
      // consumer side first since a word popped now was accepted earlier
      if (out_rd && !out_empty && model.size() != 0)
      begin
         exp = model.pop_front();
         assert (out_word == exp)
         else
         begin
            $display("FAILED %s: expected %h actual %h", name, exp, out_word);
            test_errors++;
         end
         if (prev_valid && prev_seq == 8'd255)
         begin
            wrap_seen = 1'b1;
            assert (out_word.seq == 8'd0)
            else
            begin
               $display("FAILED seq_wrap: expected %h actual %h", 8'h00, out_word.seq);
               wrap_errors++;
            end
         end
         prev_seq   = out_word.seq;
         prev_valid = 1'b1;
      end
      // host side word taken on the coming edge
      if (in_wr && !in_full)
      begin
         exp.data   = in_word.data;
         exp.last   = in_word.last;
         exp.seq    = accept_total[7:0];   // index mod 256
         exp.parity = data_parity(in_word.data);
         model.push_back(exp);
         accept_total++;
         accepted++;
      end
   endtask

   task automatic report(input string name, input int unsigned errs);
      tests_run++;
      errors += errs;
      if (errs != 0)
         tests_failed++;
      $display("%s %s: %0d errors", (errs == 0) ? "PASS" : "FAIL", name, errs);
   endtask

   //##########################################################
   // main sequence
   //##########################################################

   initial
   begin
      test_t       cur;
      string       name;
      int unsigned cycle;
      void'($urandom(60));
      chaosmode = 1'b0;
      in_wr     = 1'b0;
      in_word   = '0;
      out_rd    = 1'b0;

      // reset state
      wait (nreset === 1'b1);
      @(negedge clk);
      test_errors = 0;
      assert (in_full == 1'b0)
      else
      begin
         $display("FAILED reset_state: expected in_full %b actual %b", 1'b0, in_full);
         test_errors++;
      end
      assert (out_empty == 1'b1)
      else
      begin
         $display("FAILED reset_state: expected out_empty %b actual %b", 1'b1, out_empty);
         test_errors++;
      end
      report("reset_state", test_errors);

      for (int t = 0; t < N_TESTS; t++)
      begin
         cur         = TESTS[t];
         name        = name_of(cur.name);
         test_errors = 0;
         accepted    = 0;
         empty_reads = 0;
         chaos_seen  = 1'b0;
         cycle       = 0;
         while (accepted < cur.words || model.size() != 0)
         begin
            @(posedge clk);
            chaosmode    <= cur.chaos;
            in_wr        <= (accepted < cur.words) && (($urandom % 100) < cur.wr_pct);
            in_word.data <= $urandom;
            in_word.last <= ($urandom % 8) == 0;
            out_rd       <= (cycle >= cur.holdoff) && (($urandom % 100) < cur.rd_pct);
            @(negedge clk);
            sample_cycle(name);
            cycle++;
            if (cur.expect_cap != 0 && cycle == cur.holdoff)
            begin
               assert (accepted == cur.expect_cap)
               else
               begin
                  $display("FAILED %s: expected %0d actual %0d",
                           name, cur.expect_cap, accepted);
                  test_errors++;
               end
               assert (in_full)
               else
               begin
                  $display("FAILED %s: expected in_full %b actual %b",
                           name, 1'b1, in_full);
                  test_errors++;
               end
            end
         end
         assert (!cur.chaos || chaos_seen)
         else
         begin
            $display("%s: in_full never rose below capacity", name);
            test_errors++;
         end
         assert (!cur.idle_rd || empty_reads != 0)
         else
         begin
            $display("%s: no read was issued while empty", name);
            test_errors++;
         end
         report(name, test_errors);
      end

      // wrap check spans all tests above
      assert (wrap_seen)
      else
      begin
         $display("seq_wrap: sequence number never passed 255");
         wrap_errors++;
      end
      report("seq_wrap", wrap_errors);

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   //##########################################################
   // watchdog
   //##########################################################

   initial
   begin
      int unsigned limit;
      limit = 200;   // reset and slack
      for (int t = 0; t < N_TESTS; t++)
         limit += TESTS[t].words * 20;
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Verification failed");
      $finish;
   end

endmodule : tb_la_fifo_link

// File: la_fifo_link.f
rtl/fifo_cfg_pkg.sv
rtl/link_types_pkg.sv
rtl/la_lfsr.sv
rtl/la_syncfifo.sv
rtl/link_tagger.sv
rtl/la_fifo_link.sv
verification/tb_clkgen.sv
verification/tb_la_fifo_link.sv

// File: run.sh
#!/bin/sh
# build the fifo link testbench with verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   -f la_fifo_link.f --top-module tb_la_fifo_link -o sim_tb > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
   || { cat sim.log; echo "simulator exited with an error"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
